// ==== hw/isaPkg.sv ====
package isaPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regIdx_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_e;

    // selects which value goes back to the register file.
    typedef enum logic [1:0] {
        resAlu,
        resLoad,
        resPc4
    } resultSrc_e;

    localparam logic [6:0] opRType  = 7'b0110011;
    localparam logic [6:0] opIType  = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010;
    localparam logic [2:0] f3Beq    = 3'b000;

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Sub  = 7'b0100000;

    typedef struct packed {
        logic       regWrite;
        resultSrc_e resultSrc;
        logic       memWrite;
        logic       jump;
        logic       branch;
        aluOp_e     aluOp;
        logic       aluSrc;
    } ctrl_t;

endpackage

// ==== hw/corePkg.sv ====
package corePkg;

    typedef struct packed {
        logic          valid;
        isaPkg::word_t pc;
        isaPkg::word_t pcPlus4;
        isaPkg::word_t instr;
    } fetchDecode_t;

    // everything execute needs from decode.
    typedef struct packed {
        logic            valid;
        isaPkg::ctrl_t   ctrl;
        isaPkg::word_t   rd1;
        isaPkg::word_t   rd2;
        isaPkg::word_t   pc;
        isaPkg::word_t   pcPlus4;
        isaPkg::word_t   immExt;
        isaPkg::regIdx_t rd;
    } decodeExec_t;

    typedef struct packed {
        logic          en;
        logic          write;
        isaPkg::word_t addr;
        isaPkg::word_t wdata;
    } memReq_t;

    typedef struct packed {
        logic            en;
        isaPkg::regIdx_t rd;
        isaPkg::word_t   data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        isaPkg::word_t   pc;
        logic            regWrite;
        isaPkg::regIdx_t rd;
        isaPkg::word_t   wdata;
        logic            memWrite;
        isaPkg::word_t   addr;
        isaPkg::word_t   storeData;
    } retire_t;

endpackage

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  isaPkg::regIdx_t ra1,
    input  isaPkg::regIdx_t ra2,
    output isaPkg::word_t   rd1,
    output isaPkg::word_t   rd2,
    input  corePkg::wb_t    wb
);
    import isaPkg::*;

    word_t regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // a write in the same cycle is passed straight to the read port.
    function automatic word_t readPort(regIdx_t idx);
        if (idx == '0) return '0;
        if (wb.en && wb.rd == idx) return wb.data;
        return regs[idx];
    endfunction

    always_comb begin
        rd1 = readPort(ra1);
        rd2 = readPort(ra2);
    end

endmodule

// ==== hw/instrFetch.sv ====
`timescale 1ns/1ps

module instrFetch #(
    parameter int memWords = 1024
) (
    input  logic                 clk,
    input  logic                 rstN,
    output corePkg::memReq_t     fetchReq,
    input  logic                 fetchGrant,
    input  isaPkg::word_t        fetchData,
    input  logic                 redirectEn,
    input  isaPkg::word_t        redirectPc,
    output corePkg::fetchDecode_t fd
);
    import isaPkg::*;
    import corePkg::*;

    // the PC wraps at the end of the memory, so memWords is a power of two.
    localparam word_t addrMask = word_t'(memWords * 4 - 1);

    word_t pc;
    word_t pcPlus4;
    logic  fetchOn;

    assign pcPlus4 = pc + 32'd4;

    // fetch starts the cycle after reset is released.
    assign fetchReq = '{en: fetchOn, write: 1'b0, addr: pc, wdata: '0};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchOn <= 1'b0;
            pc <= '0;
            fd <= '0;
        end else begin
            fetchOn <= 1'b1;
            if (redirectEn) begin
                pc <= redirectPc & addrMask;
                fd.valid <= 1'b0;
            end else if (fetchGrant) begin
                pc <= pcPlus4 & addrMask;
                fd <= '{valid: 1'b1, pc: pc, pcPlus4: pcPlus4, instr: fetchData};
            end else begin
                // lost the port to a data access, so a bubble goes down.
                fd.valid <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode (
    input  logic                  clk,
    input  logic                  rstN,
    input  corePkg::fetchDecode_t fd,
    input  corePkg::wb_t          wb,
    output corePkg::decodeExec_t  de
);
    import isaPkg::*;
    import corePkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      rdata1;
    word_t      rdata2;
    word_t      immI;
    word_t      immS;
    word_t      immB;
    word_t      immJ;
    word_t      imm;
    aluOp_e     aluOp;
    logic       aluKnown;
    logic       known;
    ctrl_t      ctrl;

    assign opcode = fd.instr[6:0];
    assign funct3 = fd.instr[14:12];
    assign funct7 = fd.instr[31:25];

    assign immI = {{20{fd.instr[31]}}, fd.instr[31:20]};
    assign immS = {{20{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
    assign immB = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7], fd.instr[30:25],
                   fd.instr[11:8], 1'b0};
    assign immJ = {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12], fd.instr[20],
                   fd.instr[30:21], 1'b0};

    regFile regFile_i (
        .clk  (clk),
        .rstN (rstN),
        .ra1  (fd.instr[19:15]),
        .ra2  (fd.instr[24:20]),
        .rd1  (rdata1),
        .rd2  (rdata2),
        .wb   (wb)
    );

    always_comb begin
        aluKnown = 1'b1;
        case (funct3)
            f3AddSub: aluOp = (opcode == opRType && funct7 == f7Sub) ? aluSub : aluAdd;
            f3Slt:    aluOp = aluSlt;
            f3Or:     aluOp = aluOr;
            f3And:    aluOp = aluAnd;
            default: begin
                aluOp = aluAdd;
                aluKnown = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl = '0;
        known = 1'b0;
        imm = immI;
        case (opcode)
            opRType: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = aluOp;
                known = aluKnown &&
                        (funct7 == f7Base || (funct7 == f7Sub && funct3 == f3AddSub));
            end
            opIType: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = aluOp;
                ctrl.aluSrc = 1'b1;
                known = aluKnown;
            end
            opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.resultSrc = resLoad;
                ctrl.aluSrc = 1'b1;
                known = funct3 == f3Word;
            end
            opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                imm = immS;
                known = funct3 == f3Word;
            end
            opBranch: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp = aluSub;
                imm = immB;
                known = funct3 == f3Beq;
            end
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.resultSrc = resPc4;
                ctrl.jump = 1'b1;
                imm = immJ;
                known = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        de.valid = fd.valid && known;
        de.ctrl = de.valid ? ctrl : '0;
        de.rd1 = rdata1;
        de.rd2 = rdata2;
        de.pc = fd.pc;
        de.pcPlus4 = fd.pcPlus4;
        de.immExt = imm;
        de.rd = fd.instr[11:7];
    end

endmodule

// ==== hw/pRegDecode.sv ====
`timescale 1ns/1ps

module pRegDecode (
    input  logic                 clk,
    input  logic                 rstN,
    input  corePkg::decodeExec_t deIn,
    input  logic                 flush,
    output corePkg::decodeExec_t deOut
);
    import corePkg::*;

    decodeExec_t squashed;

    // a squashed entry keeps its payload but loses valid and every control bit.
    always_comb begin
        squashed = deIn;
        squashed.valid = 1'b0;
        squashed.ctrl = '0;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            deOut <= '0;
        end else if (flush) begin
            deOut <= squashed;
        end else begin
            deOut <= deIn;
        end
    end

endmodule

// ==== hw/execStage.sv ====
`timescale 1ns/1ps

module execStage (
    input  logic                 clk,
    input  logic                 rstN,
    input  corePkg::decodeExec_t de,
    output corePkg::memReq_t     dataReq,
    input  isaPkg::word_t        loadData,
    output corePkg::wb_t         wb,
    output logic                 redirectEn,
    output isaPkg::word_t        redirectPc,
    output corePkg::retire_t     retire
);
    import isaPkg::*;
    import corePkg::*;

    word_t   srcB;
    word_t   aluResult;
    word_t   result;
    logic    isLoad;
    retire_t retireNext;

    assign srcB = de.ctrl.aluSrc ? de.immExt : de.rd2;

    always_comb begin
        case (de.ctrl.aluOp)
            aluAdd:  aluResult = de.rd1 + srcB;
            aluSub:  aluResult = de.rd1 - srcB;
            aluAnd:  aluResult = de.rd1 & srcB;
            aluOr:   aluResult = de.rd1 | srcB;
            aluSlt:  aluResult = {31'b0, $signed(de.rd1) < $signed(srcB)};
            default: aluResult = '0;
        endcase
    end

    // beq compares through the ALU subtraction.
    assign redirectEn = de.valid && (de.ctrl.jump || (de.ctrl.branch && aluResult == '0));
    assign redirectPc = de.pc + de.immExt;

    assign isLoad = de.valid && de.ctrl.resultSrc == resLoad;

    assign dataReq = '{en: isLoad || (de.valid && de.ctrl.memWrite),
                       write: de.ctrl.memWrite,
                       addr: aluResult,
                       wdata: de.rd2};

    always_comb begin
        case (de.ctrl.resultSrc)
            resLoad: result = loadData;
            resPc4:  result = de.pcPlus4;
            default: result = aluResult;
        endcase
    end

    assign wb = '{en: de.valid && de.ctrl.regWrite, rd: de.rd, data: result};

    // fields that do not apply to the instruction are left at zero.
    always_comb begin
        retireNext = '0;
        retireNext.valid = de.valid;
        retireNext.pc = de.pc;
        retireNext.regWrite = de.ctrl.regWrite;
        retireNext.memWrite = de.ctrl.memWrite;
        if (de.ctrl.regWrite) begin
            retireNext.rd = de.rd;
            retireNext.wdata = result;
        end
        if (de.ctrl.memWrite) begin
            retireNext.addr = aluResult;
            retireNext.storeData = de.rd2;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retire <= '0;
        end else if (de.valid) begin
            retire <= retireNext;
        end else begin
            retire.valid <= 1'b0;
        end
    end

endmodule

// ==== hw/sharedMem.sv ====
`timescale 1ns/1ps

module sharedMem #(
    parameter int memWords = 1024
) (
    input  logic             clk,
    input  corePkg::memReq_t loadReq,
    input  corePkg::memReq_t dataReq,
    input  corePkg::memReq_t fetchReq,
    output isaPkg::word_t    dataRdata,
    output isaPkg::word_t    fetchRdata,
    output logic             fetchGrant
);
    import isaPkg::*;
    import corePkg::*;

    localparam int idxBits = $clog2(memWords);

    word_t                mem [memWords];
    memReq_t              portReq;
    logic [idxBits-1:0]   portIdx;
    word_t                portRdata;

    // fixed priority: loader, then data, then fetch.
    always_comb begin
        fetchGrant = 1'b0;
        if (loadReq.en) begin
            portReq = loadReq;
        end else if (dataReq.en) begin
            portReq = dataReq;
        end else begin
            portReq = fetchReq;
            fetchGrant = fetchReq.en;
        end
    end

    // word addressed; the byte offset bits are dropped.
    assign portIdx = portReq.addr[idxBits+1:2];
    assign portRdata = mem[portIdx];

    assign dataRdata = portRdata;
    assign fetchRdata = portRdata;

    always_ff @(posedge clk) begin
        if (portReq.en && portReq.write) begin
            mem[portIdx] <= portReq.wdata;
        end
    end

endmodule

// ==== hw/rvCore.sv ====
`timescale 1ns/1ps

module rvCore #(
    parameter int memWords = 1024
) (
    input  logic             clk,
    input  logic             rstN,
    input  corePkg::memReq_t loadReq,
    output corePkg::retire_t retire
);
    import isaPkg::*;
    import corePkg::*;

    memReq_t      fetchReq;
    memReq_t      dataReq;
    logic         fetchGrant;
    word_t        fetchData;
    word_t        loadData;
    logic         redirectEn;
    word_t        redirectPc;
    fetchDecode_t fd;
    decodeExec_t  deComb;
    decodeExec_t  deReg;
    wb_t          wb;

    instrFetch #(.memWords(memWords)) instrFetch_i (
        .clk        (clk),
        .rstN       (rstN),
        .fetchReq   (fetchReq),
        .fetchGrant (fetchGrant),
        .fetchData  (fetchData),
        .redirectEn (redirectEn),
        .redirectPc (redirectPc),
        .fd         (fd)
    );

    instrDecode instrDecode_i (
        .clk  (clk),
        .rstN (rstN),
        .fd   (fd),
        .wb   (wb),
        .de   (deComb)
    );

    // a taken branch or jal squashes the instruction in decode.
    pRegDecode pRegDecode_i (
        .clk   (clk),
        .rstN  (rstN),
        .deIn  (deComb),
        .flush (redirectEn),
        .deOut (deReg)
    );

    execStage execStage_i (
        .clk        (clk),
        .rstN       (rstN),
        .de         (deReg),
        .dataReq    (dataReq),
        .loadData   (loadData),
        .wb         (wb),
        .redirectEn (redirectEn),
        .redirectPc (redirectPc),
        .retire     (retire)
    );

    sharedMem #(.memWords(memWords)) sharedMem_i (
        .clk        (clk),
        .loadReq    (loadReq),
        .dataReq    (dataReq),
        .fetchReq   (fetchReq),
        .dataRdata  (loadData),
        .fetchRdata (fetchData),
        .fetchGrant (fetchGrant)
    );

endmodule

// ==== bench/refModel.svh ====
function automatic word_t rTypeWord(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opRType};
endfunction

function automatic word_t iTypeWord(logic [6:0] op, logic [2:0] f3, int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), op};
endfunction

function automatic word_t storeWord(int rs2, int rs1, int imm);
    word_t off;
    off = word_t'(imm);
    return {off[11:5], 5'(rs2), 5'(rs1), f3Word, off[4:0], opStore};
endfunction

function automatic word_t branchWord(int rs1, int rs2, int imm);
    word_t off;
    off = word_t'(imm);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3Beq, off[4:1], off[11], opBranch};
endfunction

function automatic word_t jalWord(int rd, int imm);
    word_t off;
    off = word_t'(imm);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rd), opJal};
endfunction

// data words depend on every address bit, so a wrong index reads a different value.
function automatic word_t fillWord(int idx);
    return (word_t'(idx * 4) * 32'h9E3779B1) ^ word_t'(testsPassed * 32'h01000193);
endfunction

function automatic void prepareImage();
    foreach (modelMem[i]) begin
        modelMem[i] = '0;
    end
    foreach (progQ[i]) begin
        modelMem[i] = progQ[i];
    end
    for (int i = dataBaseWord; i < dataBaseWord + dataWords; i++) begin
        modelMem[i] = fillWord(i);
    end
    foreach (modelRegs[i]) begin
        modelRegs[i] = '0;
    end
    modelPc = '0;
endfunction

// executes one instruction on the architectural state and returns what should retire.
function automatic retire_t modelStep();
    word_t   instr;
    word_t   a;
    word_t   b;
    word_t   immI;
    word_t   value;
    word_t   addr;
    word_t   nextPc;
    regIdx_t rd;
    retire_t r;
    instr = modelMem[modelPc[11:2]];
    rd = instr[11:7];
    a = modelRegs[instr[19:15]];
    b = modelRegs[instr[24:20]];
    immI = {{20{instr[31]}}, instr[31:20]};
    nextPc = modelPc + 32'd4;
    value = '0;
    r = '0;
    r.valid = 1'b1;
    r.pc = modelPc;
    case (instr[6:0])
        opRType, opIType: begin
            if (instr[6:0] == opIType) begin
                b = immI;
            end
            case (instr[14:12])
                f3AddSub: value = (instr[6:0] == opRType && instr[30]) ? a - b : a + b;
                f3Slt:    value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                f3Or:     value = a | b;
                default:  value = a & b;
            endcase
            r.regWrite = 1'b1;
        end
        opLoad: begin
            addr = a + immI;
            value = modelMem[addr[11:2]];
            r.regWrite = 1'b1;
        end
        opStore: begin
            addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
            modelMem[addr[11:2]] = b;
            r.memWrite = 1'b1;
            r.addr = addr;
            r.storeData = b;
        end
        opBranch: begin
            if (a == b) begin
                nextPc = modelPc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                    instr[11:8], 1'b0};
            end
        end
        opJal: begin
            value = modelPc + 32'd4;
            r.regWrite = 1'b1;
            nextPc = modelPc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                instr[30:21], 1'b0};
        end
        default: ;
    endcase
    if (r.regWrite) begin
        r.rd = rd;
        r.wdata = value;
        if (rd != '0) begin
            modelRegs[rd] = value;
        end
    end
    modelPc = nextPc;
    return r;
endfunction

function automatic int runModel(word_t haltPc);
    retire_t r;
    int      steps;
    expQ.delete();
    steps = 0;
    do begin
        r = modelStep();
        expQ.push_back(r);
        steps++;
    end while (r.pc != haltPc && steps < 4 * progWords);
    if (r.pc != haltPc) begin
        $display("reference model did not reach the halt instruction");
        stopOnFailure();
    end
    return steps;
endfunction

function automatic logic [2:0] pickAluF3();
    case ($urandom % 4)
        0:       return f3AddSub;
        1:       return f3Slt;
        2:       return f3Or;
        default: return f3And;
    endcase
endfunction

// x1 holds the data base, so random code never writes it.
function automatic int destReg();
    int r;
    r = int'($urandom % 16);
    return (r == 1) ? 0 : r;
endfunction

function automatic int srcReg();
    return int'($urandom % 16);
endfunction

function automatic void randomProgram();
    int         haltIdx;
    int         target;
    logic [2:0] f3;
    progQ.delete();
    haltIdx = 11 + int'($urandom % 50);
    progQ.push_back(iTypeWord(opIType, f3AddSub, 1, 0, dataBaseWord * 4));
    for (int i = 1; i < haltIdx; i++) begin
        target = i + 1 + int'($urandom % 4);
        if (target > haltIdx) begin
            target = haltIdx;
        end
        f3 = pickAluF3();
        case ($urandom % 10)
            0, 1, 2, 3: begin
                progQ.push_back(rTypeWord((f3 == f3AddSub && $urandom % 2 == 1) ? f7Sub : f7Base,
                                          f3, destReg(), srcReg(), srcReg()));
            end
            4, 5: progQ.push_back(iTypeWord(opIType, f3, destReg(), srcReg(),
                                            int'($urandom % 4096) - 2048));
            6: progQ.push_back(iTypeWord(opLoad, f3Word, destReg(), 1, 4 * int'($urandom % 64)));
            7: progQ.push_back(storeWord(srcReg(), 1, 4 * int'($urandom % 64)));
            8: progQ.push_back(branchWord(srcReg(), srcReg(), 4 * (target - i)));
            default: progQ.push_back(jalWord(destReg(), 4 * (target - i)));
        endcase
    end
    progQ.push_back(jalWord(0, 0));
endfunction

// ==== bench/rvCoreTb.sv ====
`timescale 1ns/1ps

module rvCoreTb;
    import isaPkg::*;
    import corePkg::*;

    localparam int memWords = 1024;
    localparam int progWords = 128;
    localparam int dataBaseWord = 256;
    localparam int dataWords = 64;
    localparam int resetCycles = 5;
    localparam int numRandom = 20;
    localparam int numTests = 4 + numRandom;

    logic    clk;
    logic    rstN;
    memReq_t loadReq;
    retire_t retire;

    word_t   modelMem [memWords];
    word_t   modelRegs [32];
    word_t   modelPc;
    word_t   progQ [$];
    retire_t expQ [$];
    string   testName;
    logic    strictTiming;
    int      cycleCount = 0;
    int      cycleBudget = 0;
    int      armedId = 0;
    int      doneId = 0;
    int      expIdx = 0;
    int      lastRetireCycle = 0;
    int      testsPassed = 0;

    function automatic void stopOnFailure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at the first failure");
    endfunction

    `include "refModel.svh"

    rvCore #(.memWords(memWords)) rvCore_i (
        .clk     (clk),
        .rstN    (rstN),
        .loadReq (loadReq),
        .retire  (retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > cycleBudget) begin
                $display("watchdog expired after %0d clock cycles", cycleCount);
                stopOnFailure();
            end
        end
    end

    task automatic expectWord(string field, word_t expVal, word_t actVal);
        assert (actVal == expVal) else begin
            $display("ERROR %s %s: expected %h actual %h", testName, field, expVal, actVal);
            stopOnFailure();
        end
    endtask

    task automatic compareRetire(retire_t expRec);
        if (expIdx == 0) begin
            expectWord("first pc", '0, retire.pc);
        end else if (strictTiming) begin
            expectWord("retire spacing", 32'd1, word_t'(cycleCount - lastRetireCycle));
        end
        expectWord("pc", expRec.pc, retire.pc);
        expectWord("regWrite", word_t'(expRec.regWrite), word_t'(retire.regWrite));
        expectWord("rd", word_t'(expRec.rd), word_t'(retire.rd));
        expectWord("wdata", expRec.wdata, retire.wdata);
        expectWord("memWrite", word_t'(expRec.memWrite), word_t'(retire.memWrite));
        expectWord("addr", expRec.addr, retire.addr);
        expectWord("storeData", expRec.storeData, retire.storeData);
        lastRetireCycle = cycleCount;
        expIdx++;
        // the last record is the halt jal, which ends the test.
        if (expIdx == expQ.size()) begin
            expIdx = 0;
            doneId = armedId;
        end
    endtask

    // retire is registered, so the falling edge sees a settled value.
    always @(negedge clk) begin
        if (!rstN) begin
            assert (!retire.valid) else begin
                $display("retire.valid was high while the core was held in reset");
                stopOnFailure();
            end
        end else if (armedId != doneId && retire.valid) begin
            compareRetire(expQ[expIdx]);
        end
    end

    task automatic writeMemWord(int idx);
        loadReq <= '{en: 1'b1, write: 1'b1, addr: word_t'(idx * 4), wdata: modelMem[idx]};
        @(posedge clk);
    endtask

    task automatic loadImage();
        for (int i = 0; i < progWords; i++) begin
            writeMemWord(i);
        end
        for (int i = dataBaseWord; i < dataBaseWord + dataWords; i++) begin
            writeMemWord(i);
        end
    endtask

    task automatic runTest(string name, logic strict);
        int steps;
        testName = name;
        strictTiming = strict;
        prepareImage();
        cycleBudget += resetCycles + progWords + dataWords + 2;
        @(posedge clk);
        rstN <= 1'b0;
        loadReq <= '0;
        repeat (resetCycles) @(posedge clk);
        loadImage();
        loadReq <= '0;
        steps = runModel(word_t'(4 * (progQ.size() - 1)));
        // a few extra cycles cover the pipeline fill.
        cycleBudget += 4 * steps + 8;
        armedId = armedId + 1;
        @(posedge clk);
        rstN <= 1'b1;
        wait (doneId == armedId);
        testsPassed++;
    endtask

    task automatic aluProgram();
        progQ.delete();
        progQ.push_back(iTypeWord(opIType, f3AddSub, 1, 0, 5));
        progQ.push_back(iTypeWord(opIType, f3AddSub, 2, 0, -7));
        progQ.push_back(rTypeWord(f7Base, f3AddSub, 3, 1, 2));
        progQ.push_back(rTypeWord(f7Sub, f3AddSub, 4, 1, 2));
        progQ.push_back(rTypeWord(f7Base, f3And, 5, 1, 2));
        progQ.push_back(rTypeWord(f7Base, f3Or, 6, 1, 2));
        progQ.push_back(rTypeWord(f7Base, f3Slt, 7, 2, 1));
        progQ.push_back(rTypeWord(f7Base, f3Slt, 8, 1, 2));
        progQ.push_back(iTypeWord(opIType, f3Slt, 9, 2, -3));
        progQ.push_back(iTypeWord(opIType, f3Slt, 10, 2, -8));
        progQ.push_back(iTypeWord(opIType, f3And, 11, 2, 'h0f0));
        progQ.push_back(iTypeWord(opIType, f3Or, 12, 1, -256));
        // x0 is written twice and then read back.
        progQ.push_back(iTypeWord(opIType, f3AddSub, 0, 1, 9));
        progQ.push_back(rTypeWord(f7Base, f3AddSub, 0, 1, 1));
        progQ.push_back(rTypeWord(f7Base, f3Or, 13, 0, 1));
        progQ.push_back(jalWord(0, 0));
    endtask

    task automatic loadStoreProgram();
        progQ.delete();
        progQ.push_back(iTypeWord(opIType, f3AddSub, 1, 0, dataBaseWord * 4));
        progQ.push_back(iTypeWord(opIType, f3AddSub, 2, 0, 123));
        progQ.push_back(storeWord(2, 1, 0));
        progQ.push_back(iTypeWord(opLoad, f3Word, 3, 1, 0));
        progQ.push_back(storeWord(3, 1, 4));
        progQ.push_back(iTypeWord(opLoad, f3Word, 4, 1, 4));
        progQ.push_back(iTypeWord(opLoad, f3Word, 5, 1, 8));
        progQ.push_back(iTypeWord(opIType, f3AddSub, 6, 0, -1));
        progQ.push_back(storeWord(6, 1, 8));
        progQ.push_back(iTypeWord(opLoad, f3Word, 7, 1, 8));
        progQ.push_back(rTypeWord(f7Base, f3AddSub, 8, 7, 5));
        progQ.push_back(jalWord(0, 0));
    endtask

    task automatic forwardProgram();
        progQ.delete();
        progQ.push_back(iTypeWord(opIType, f3AddSub, 1, 0, 1));
        progQ.push_back(rTypeWord(f7Base, f3AddSub, 1, 1, 1));
        progQ.push_back(rTypeWord(f7Base, f3AddSub, 1, 1, 1));
        progQ.push_back(iTypeWord(opIType, f3AddSub, 2, 1, 3));
        progQ.push_back(rTypeWord(f7Sub, f3AddSub, 3, 2, 1));
        progQ.push_back(rTypeWord(f7Base, f3Or, 4, 3, 2));
        progQ.push_back(rTypeWord(f7Base, f3Slt, 5, 4, 3));
        progQ.push_back(jalWord(0, 0));
    endtask

    task automatic branchProgram();
        progQ.delete();
        progQ.push_back(iTypeWord(opIType, f3AddSub, 1, 0, 3));
        progQ.push_back(iTypeWord(opIType, f3AddSub, 2, 0, 3));
        progQ.push_back(branchWord(1, 2, 12));
        progQ.push_back(iTypeWord(opIType, f3AddSub, 3, 0, 1));
        progQ.push_back(iTypeWord(opIType, f3AddSub, 4, 0, 1));
        progQ.push_back(branchWord(1, 0, 8));
        progQ.push_back(iTypeWord(opIType, f3AddSub, 5, 0, 2));
        progQ.push_back(jalWord(7, 8));
        progQ.push_back(iTypeWord(opIType, f3AddSub, 8, 0, 9));
        progQ.push_back(rTypeWord(f7Base, f3AddSub, 9, 7, 5));
        progQ.push_back(branchWord(0, 0, 8));
        progQ.push_back(iTypeWord(opIType, f3AddSub, 10, 0, 1));
        progQ.push_back(jalWord(0, 0));
    endtask

    initial begin
        void'($urandom(32'h4c78fc37));
        rstN = 1'b0;
        loadReq = '0;
        aluProgram();
        runTest("alu", 1'b0);
        loadStoreProgram();
        runTest("loadStore", 1'b0);
        forwardProgram();
        runTest("forward", 1'b1);
        branchProgram();
        runTest("branch", 1'b0);
        for (int t = 0; t < numRandom; t++) begin
            randomProgram();
            runTest($sformatf("random%0d", t), 1'b0);
        end
        if (testsPassed == numTests) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+bench
hw/isaPkg.sv
hw/corePkg.sv
hw/regFile.sv
hw/instrFetch.sv
hw/instrDecode.sv
hw/pRegDecode.sv
hw/execStage.sv
hw/sharedMem.sv
hw/rvCore.sv
bench/rvCoreTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rvCoreTb -f vlog.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VrvCoreTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
